//--- tests/arb_stim.txt
# Per master 0..2: valid write addr wdata offset exp_rdata, then the done order (f = none).
# All fields hex; exp_rdata is checked for reads only, offsets are cycles from batch start.
# Single write, then read back.
1 1 05 1234 0 0000  0 0 00 0000 0 0000  0 0 00 0000 0 0000  0 f f
1 0 05 0000 0 1234  0 0 00 0000 0 0000  0 0 00 0000 0 0000  0 f f
# All masters on the same cycle.
1 1 10 aaaa 0 0000  1 1 11 bbbb 0 0000  1 1 12 cccc 0 0000  0 1 2
1 0 12 0000 0 cccc  1 0 11 0000 0 bbbb  1 0 10 0000 0 aaaa  0 1 2
# Master 0 writes before master 1 reads.
1 1 20 5a5a 0 0000  1 0 20 0000 0 5a5a  0 0 00 0000 0 0000  0 1 f
# Grant held until ack.
1 0 30 0000 3 7777  0 0 00 0000 0 0000  1 1 30 7777 0 0000  2 0 f
0 0 00 0000 0 0000  1 0 3f 0000 2 ffff  1 1 3f ffff 0 0000  2 1 f
1 1 00 0002 1 0000  1 1 00 0001 0 0000  1 0 00 0000 1 0002  1 0 2
1 0 05 0000 2 1234  1 0 3f 0000 0 ffff  1 0 00 0000 1 0002  1 0 2
0 0 00 0000 0 0000  0 0 00 0000 0 0000  1 1 2a 0f0f 0 0000  2 f f
0 0 00 0000 0 0000  0 0 00 0000 0 0000  1 0 2a 0000 0 0f0f  2 f f
1 1 01 dead 0 0000  1 1 02 beef 0 0000  1 0 01 0000 0 dead  0 1 2
0 0 00 0000 0 0000  1 0 02 0000 0 beef  0 0 00 0000 0 0000  1 f f
1 0 01 0000 1 4321  1 1 01 4321 0 0000  1 0 01 0000 1 4321  1 0 2
1 0 15 0000 3 1111  1 1 15 2222 3 0000  1 1 15 1111 0 0000  2 0 1
1 0 15 0000 0 2222  0 0 00 0000 0 0000  0 0 00 0000 0 0000  0 f f
0 0 00 0000 0 0000  1 1 33 0000 0 0000  1 1 34 ffff 0 0000  1 2 f
1 0 34 0000 1 ffff  1 0 33 0000 0 0000  1 0 05 0000 0 1234  1 0 2
1 1 3e abcd 0 0000  1 1 3e dcba 1 0000  1 0 3e 0000 5 dcba  0 1 2
0 0 00 0000 0 0000  1 0 3e 0000 0 dcba  0 0 00 0000 0 0000  1 f f

//--- build.f
+incdir+hdl
hdl/arb_pkg.sv
hdl/busarbiter.sv
hdl/bus_client.sv
hdl/shared_mem.sv
hdl/arb_system.sv
tests/arb_system_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the arbiter testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing -f build.f --top-module arb_system_tb -o arb_sim \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/arb_sim > "$LOG" 2>&1
cat "$LOG"

grep -q 'Test failures found' "$LOG" && { echo "Simulation FAILED"; exit 1; }
grep -q 'All tests passed!' "$LOG" || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation PASSED"

//--- tests/arb_system_tb.sv
`timescale 1ns/100ps
`include "arb_config.svh"

module arb_system_tb
    import arb_pkg::*;
();

    localparam int STIM_MASTERS = 3;
    localparam int MAX_BATCH    = 64;

    logic                   clk;
    logic                   reset;
    logic  [`N_MASTERS-1:0] cmd_valid;
    logic  [`N_MASTERS-1:0] cmd_write;
    addr_t [`N_MASTERS-1:0] cmd_addr;
    data_t [`N_MASTERS-1:0] cmd_wdata;
    logic  [`N_MASTERS-1:0] busy;
    logic  [`N_MASTERS-1:0] done;
    data_t [`N_MASTERS-1:0] rdata;

    // One row per batch, one column per master.
    int st_valid [MAX_BATCH][STIM_MASTERS];
    int st_write [MAX_BATCH][STIM_MASTERS];
    int st_addr  [MAX_BATCH][STIM_MASTERS];
    int st_wdata [MAX_BATCH][STIM_MASTERS];
    int st_off   [MAX_BATCH][STIM_MASTERS];
    int st_exp   [MAX_BATCH][STIM_MASTERS];
    int st_order [MAX_BATCH][STIM_MASTERS];

    int   n_batches;
    logic loaded;

    // Expectations of the batch in flight, used by the done monitor.
    logic cur_read [STIM_MASTERS];
    int   cur_exp  [STIM_MASTERS];
    int   done_order [$];

    arb_system dut (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd_write (cmd_write),
        .cmd_addr  (cmd_addr),
        .cmd_wdata (cmd_wdata),
        .busy      (busy),
        .done      (done),
        .rdata     (rdata)
    );

    always #10 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL time=%0t %s actual=0x%0h expected=0x%0h",
                     $time, name, actual, expected);
            $display("Test failures found");
            $fatal(1, "Stopping at the first mismatch.");
        end
    endtask

    task automatic stop_with_error(input string reason);
        $display("ERROR time=%0t %s", $time, reason);
        $display("Test failures found");
        $fatal(1, "Run aborted.");
    endtask

    task automatic load_stim();
        int    fd;
        int    n;
        string line;
        fd = $fopen("tests/arb_stim.txt", "r");
        if (fd == 0) begin
            stop_with_error("cannot open the stimulus file tests/arb_stim.txt");
        end
        n_batches = 0;
        while ($fgets(line, fd) != 0) begin
            // Skip comments and blank lines.
            if (line.len() > 1 && line.getc(0) != "#") begin
                if (n_batches == MAX_BATCH) begin
                    stop_with_error("the stimulus file holds too many batches");
                end
                n = $sscanf(line,
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    st_valid[n_batches][0], st_write[n_batches][0], st_addr[n_batches][0],
                    st_wdata[n_batches][0], st_off[n_batches][0], st_exp[n_batches][0],
                    st_valid[n_batches][1], st_write[n_batches][1], st_addr[n_batches][1],
                    st_wdata[n_batches][1], st_off[n_batches][1], st_exp[n_batches][1],
                    st_valid[n_batches][2], st_write[n_batches][2], st_addr[n_batches][2],
                    st_wdata[n_batches][2], st_off[n_batches][2], st_exp[n_batches][2],
                    st_order[n_batches][0], st_order[n_batches][1], st_order[n_batches][2]);
                if (n != 21) begin
                    stop_with_error($sformatf("stimulus line %0d is malformed", n_batches));
                end
                n_batches++;
            end
        end
        $fclose(fd);
    endtask

    // Issue one batch, wait for every issued master, then check the order.
    task automatic run_batch(input int b);
        int n_issued;
        int max_off;
        n_issued = 0;
        max_off  = 0;
        done_order.delete();
        for (int m = 0; m < STIM_MASTERS; m++) begin
            cur_read[m] = (st_valid[b][m] != 0) && (st_write[b][m] == 0);
            cur_exp[m]  = st_exp[b][m];
            if (st_valid[b][m] != 0) begin
                n_issued++;
                if (st_off[b][m] > max_off) begin
                    max_off = st_off[b][m];
                end
            end
        end
        for (int t = 0; t <= max_off; t++) begin
            for (int m = 0; m < STIM_MASTERS; m++) begin
                cmd_valid[m] = (st_valid[b][m] != 0) && (st_off[b][m] == t);
                cmd_write[m] = (st_write[b][m] != 0);
                cmd_addr[m]  = addr_t'(st_addr[b][m]);
                cmd_wdata[m] = data_t'(st_wdata[b][m]);
            end
            @(posedge clk);
            #1;
        end
        cmd_valid = '0;
        while (done_order.size() < n_issued) begin
            @(posedge clk);
            #1;
        end
        // One spare cycle so a stray done shows up in the count.
        @(posedge clk);
        #1;
        check_value($sformatf("done count batch %0d", b), done_order.size(), n_issued);
        for (int i = 0; i < n_issued; i++) begin
            check_value($sformatf("done order[%0d] batch %0d", i, b),
                        done_order[i], st_order[b][i]);
        end
    endtask

    // Done monitor, sampled away from the active edge.
    always @(negedge clk) begin
        if (!reset) begin
            if ($countones(done) > 1) begin
                check_value("done pulses in one cycle", $countones(done), 1);
            end
            for (int m = 0; m < STIM_MASTERS; m++) begin
                if (done[m]) begin
                    done_order.push_back(m);
                    if (cur_read[m]) begin
                        check_value($sformatf("rdata[%0d]", m), 32'(rdata[m]), cur_exp[m]);
                    end
                end
            end
        end
    end

    initial begin
        wait (loaded);
        repeat (n_batches * 3 * (`MEM_LATENCY + 6) + 200) @(posedge clk);
        stop_with_error("timeout, done never arrived for the batch in flight");
    end

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        cmd_valid  = '0;
        cmd_write  = '0;
        cmd_addr   = '0;
        cmd_wdata  = '0;
        loaded     = 1'b0;
        for (int m = 0; m < STIM_MASTERS; m++) begin
            cur_read[m] = 1'b0;
            cur_exp[m]  = 0;
        end
        if (`N_MASTERS != STIM_MASTERS) begin
            stop_with_error("the stimulus file is written for three masters");
        end
        load_stim();
        loaded = 1'b1;

        repeat (8) @(posedge clk);
        #1;
        check_value("busy in reset", 32'(busy), 0);
        check_value("done in reset", 32'(done), 0);
        reset = 1'b0;
        @(posedge clk);
        #1;
        check_value("busy after reset", 32'(busy), 0);
        check_value("done after reset", 32'(done), 0);

        for (int b = 0; b < n_batches; b++) begin
            run_batch(b);
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

//--- hdl/arb_system.sv
`timescale 1ns/100ps
`include "arb_config.svh"

module arb_system
    import arb_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic  [`N_MASTERS-1:0] cmd_valid,
    input  logic  [`N_MASTERS-1:0] cmd_write,
    input  addr_t [`N_MASTERS-1:0] cmd_addr,
    input  data_t [`N_MASTERS-1:0] cmd_wdata,
    output logic  [`N_MASTERS-1:0] busy,
    output logic  [`N_MASTERS-1:0] done,
    output data_t [`N_MASTERS-1:0] rdata
);

    arb_vector                bus_req;
    arb_vector                bus_grant;
    logic                     bus_ack;
    data_t                    bus_rdata;
    logic  [`N_MASTERS-1:0]   req_write;
    addr_t [`N_MASTERS-1:0]   req_addr;
    data_t [`N_MASTERS-1:0]   req_wdata;

    busarbiter u_arbiter (
        .clk       (clk),
        .reset     (reset),
        .bus_ack   (bus_ack),
        .bus_req   (bus_req),
        .bus_grant (bus_grant)
    );

    shared_mem u_mem (
        .clk       (clk),
        .reset     (reset),
        .bus_grant (bus_grant),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .bus_ack   (bus_ack),
        .bus_rdata (bus_rdata)
    );

    // One client per master, ack and read data are shared.
    for (genvar m = 0; m < `N_MASTERS; m++) begin : g_client
        bus_client u_client (
            .clk          (clk),
            .reset        (reset),
            .cmd_valid    (cmd_valid[m]),
            .cmd_write    (cmd_write[m]),
            .cmd_addr     (cmd_addr[m]),
            .cmd_wdata    (cmd_wdata[m]),
            .busy         (busy[m]),
            .done         (done[m]),
            .rdata        (rdata[m]),
            .bus_grant_me (bus_grant[m]),
            .bus_ack      (bus_ack),
            .bus_rdata    (bus_rdata),
            .bus_req_me   (bus_req[m]),
            .req_write    (req_write[m]),
            .req_addr     (req_addr[m]),
            .req_wdata    (req_wdata[m])
        );
    end

endmodule

//--- hdl/shared_mem.sv
`timescale 1ns/100ps
`include "arb_config.svh"

module shared_mem
    import arb_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  arb_vector             bus_grant,
    input  logic [`N_MASTERS-1:0] req_write,
    input  addr_t [`N_MASTERS-1:0] req_addr,
    input  data_t [`N_MASTERS-1:0] req_wdata,
    output logic                  bus_ack,
    output data_t                 bus_rdata
);

    localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

    data_t mem [`MEM_DEPTH];

    logic             sel_write;
    addr_t            sel_addr;
    data_t            sel_wdata;
    logic             active;
    logic             start;
    logic [CNT_W-1:0] cnt;

    // One-hot grant picks the client's request.
    always_comb begin
        sel_write = 1'b0;
        sel_addr  = '0;
        sel_wdata = '0;
        for (int i = 0; i < `N_MASTERS; i++) begin
            if (bus_grant[i]) begin
                sel_write = req_write[i];
                sel_addr  = req_addr[i];
                sel_wdata = req_wdata[i];
            end
        end
    end

    // Skip the ack cycle, the grant is stale there.
    assign start = !active && !bus_ack && (bus_grant != NO_GRANT);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active  <= 1'b0;
            cnt     <= '0;
            bus_ack <= 1'b0;
        end else begin
            bus_ack <= 1'b0;
            if (!active) begin
                if (start) begin
                    active <= 1'b1;
                    cnt    <= CNT_W'(`MEM_LATENCY - 1);
                end
            end else if (cnt == '0) begin
                active  <= 1'b0;
                bus_ack <= 1'b1;
            end else begin
                cnt <= cnt - CNT_W'(1);
            end
        end
    end

    // Access happens at latch time, the word waits for the ack.
    always_ff @(posedge clk) begin
        if (start) begin
            if (sel_write) begin
                mem[sel_addr] <= sel_wdata;
                bus_rdata     <= sel_wdata;
            end else begin
                bus_rdata <= mem[sel_addr];
            end
        end
    end

endmodule

//--- hdl/bus_client.sv
`timescale 1ns/100ps

module bus_client
    import arb_pkg::*;
(
    input  logic  clk,
    input  logic  reset,

    // Command side.
    input  logic  cmd_valid,
    input  logic  cmd_write,
    input  addr_t cmd_addr,
    input  data_t cmd_wdata,
    output logic  busy,
    output logic  done,
    output data_t rdata,

    // Bus side.
    input  logic  bus_grant_me,
    input  logic  bus_ack,
    input  data_t bus_rdata,
    output logic  bus_req_me,
    output logic  req_write,
    output addr_t req_addr,
    output data_t req_wdata
);

    logic accept;
    logic finish;

    assign accept = cmd_valid && !busy;
    assign finish = busy && bus_grant_me && bus_ack;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy       <= 1'b0;
            done       <= 1'b0;
            bus_req_me <= 1'b0;
        end else begin
            done <= 1'b0;
            if (accept) begin
                busy       <= 1'b1;
                bus_req_me <= 1'b1;
            end else if (busy) begin
                // Arbiter keeps the grant on its own once given.
                if (bus_grant_me) begin
                    bus_req_me <= 1'b0;
                end
                if (finish) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // Held stable until done.
    always_ff @(posedge clk) begin
        if (accept) begin
            req_write <= cmd_write;
            req_addr  <= cmd_addr;
            req_wdata <= cmd_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (finish) begin
            rdata <= bus_rdata;
        end
    end

endmodule

//--- hdl/busarbiter.sv
`timescale 1ns/100ps

module busarbiter
    import arb_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      bus_ack,
    input  arb_vector bus_req,
    output arb_vector bus_grant
);

    arb_state_t state;
    arb_vector  prio_req;
    logic       any_req;

    // Isolate the lowest set request bit.
    always_comb begin
        prio_req = bus_req & (~bus_req + arb_vector'(1));
    end

    assign any_req = (bus_req != NO_GRANT);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= READY;
            bus_grant <= NO_GRANT;
        end else begin
            case (state)
                READY: begin
                    // Grant follows the requests every cycle while idle.
                    bus_grant <= prio_req;
                    if (any_req) begin
                        state <= BUSY;
                    end
                end
                BUSY: begin
                    // Held until the memory finishes, no pre-emption.
                    if (bus_ack) begin
                        bus_grant <= prio_req;
                        state     <= any_req ? BUSY : READY;
                    end
                end
                default: begin
                    state     <= READY;
                    bus_grant <= NO_GRANT;
                end
            endcase
        end
    end

endmodule

//--- hdl/arb_pkg.sv
`include "arb_config.svh"

package arb_pkg;

    // One bit per master, index 0 has the highest priority.
    typedef logic [`N_MASTERS-1:0] arb_vector;

    typedef logic [`ADDR_WIDTH-1:0] addr_t;
    typedef logic [`DATA_WIDTH-1:0] data_t;

    typedef enum logic {
        READY,
        BUSY
    } arb_state_t;

    localparam arb_vector NO_GRANT = '0;

endpackage

//--- hdl/arb_config.svh
`ifndef ARB_CONFIG_SVH
`define ARB_CONFIG_SVH

// Number of peer bus clients.
`define N_MASTERS 3

// Memory word and word address widths.
`define DATA_WIDTH 16
`define ADDR_WIDTH 6

// One word per address.
`define MEM_DEPTH (1 << `ADDR_WIDTH)

// Cycles from access start to acknowledge, at least 1.
`define MEM_LATENCY 2

`endif
